/* Makefile */
SRCS := $(shell cat vlog.f)

.PHONY: run clean

obj_dir/VmicroSequencerTb: vlog.f $(SRCS)
	verilator --binary --timing -f vlog.f --top-module microSequencerTb \
		-o VmicroSequencerTb

run: obj_dir/VmicroSequencerTb
	./obj_dir/VmicroSequencerTb | tee /dev/stderr | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

/* common/seqPkg.sv */
`default_nettype none

package seqPkg;

  ////////////////////////////////////////////////////////////
  // Microword layout
  ////////////////////////////////////////////////////////////

  // J[10:0], op[13:11], cond[16:14]
  localparam int JUMP_W      = 11;
  localparam int OP_W        = 3;
  localparam int COND_W      = 3;
  localparam int MICROWORD_W = 17;

  // Dispatch opcode in the op field
  typedef enum logic [OP_W-1:0] {
    DISP_NONE   = 3'd0,
    DISP_SKIP   = 3'd1,
    DISP_NIBBLE = 3'd2,
    DISP_IR     = 3'd3,
    DISP_DIAG   = 3'd4,
    DISP_CALL   = 3'd5,
    DISP_RETURN = 3'd6
  } dispOp_t;

  ////////////////////////////////////////////////////////////
  // APB register map, byte offsets
  ////////////////////////////////////////////////////////////

  typedef enum logic [11:0] {
    REG_CTRL   = 12'h000,
    REG_DIAG   = 12'h004,
    REG_CRADR  = 12'h008,
    REG_STACK  = 12'h00C,
    REG_RETURN = 12'h010,
    // Control store word i lives at CS_BASE + 4*i
    CS_BASE    = 12'h400
  } regAddr_t;

endpackage

`default_nettype wire

/* crAddress/nextAddress.sv */
`timescale 1ns/1ps
`default_nettype none

module nextAddress
  import seqPkg::*;
#(
  parameter int ADDR_WIDTH = 11
) (
  input  logic                  CLK,
  input  logic                  RESET,
  input  logic                  advance,
  input  logic                  forceOnes,
  input  dispOp_t               muxSel,
  input  logic [JUMP_W-1:0]     jump,
  input  logic [COND_W-1:0]     cond,
  input  logic [7:0]            conditions,
  input  logic [3:0]            dispNibble,
  input  logic [ADDR_WIDTH-1:0] irJump,
  input  logic [ADDR_WIDTH-1:0] diagAddr,
  input  logic [ADDR_WIDTH-1:0] returnAddr,
  output logic [ADDR_WIDTH-1:0] cradr
);

  logic [ADDR_WIDTH-1:0] dispMux;
  logic [ADDR_WIDTH-1:0] jumpExt;
  logic [ADDR_WIDTH-1:0] nextAdr;

  assign jumpExt = ADDR_WIDTH'(jump);

  ////////////////////////////////////////////////////////////
  // Dispatch mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (muxSel)
      // Skip lands on J or J+1 via bit 0
      DISP_SKIP:   dispMux = ADDR_WIDTH'(conditions[cond]);
      DISP_NIBBLE: dispMux = ADDR_WIDTH'(dispNibble);
      DISP_IR:     dispMux = irJump;
      DISP_DIAG:   dispMux = diagAddr;
      DISP_RETURN: dispMux = returnAddr;
      // NONE and CALL both go straight to J
      default:     dispMux = '0;
    endcase
  end

  // All ones is the trap entry point
  assign nextAdr = forceOnes ? {ADDR_WIDTH{1'b1}} : (jumpExt | dispMux);

  ////////////////////////////////////////////////////////////
  // Current address register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      cradr <= '0;
    end else if (advance) begin
      cradr <= nextAdr;
    end
  end

endmodule

`default_nettype wire

/* crAddress/returnStack.sv */
`timescale 1ns/1ps
`default_nettype none

module returnStack #(
  parameter int ADDR_WIDTH  = 11,
  parameter int STACK_DEPTH = 16
) (
  input  logic                           CLK,
  input  logic                           RESET,
  input  logic                           push,
  input  logic                           pop,
  input  logic [ADDR_WIDTH-1:0]          pushData,
  output logic [ADDR_WIDTH-1:0]          returnAddr,
  output logic [$clog2(STACK_DEPTH)-1:0] stackPtr,
  output logic [$clog2(STACK_DEPTH):0]   stackDepth
);

  localparam int PTR_W = $clog2(STACK_DEPTH);

  logic [ADDR_WIDTH-1:0] stack [STACK_DEPTH];
  logic [ADDR_WIDTH-1:0] topReg;
  logic [PTR_W-1:0]      ptrBelow;

  // Entry that becomes the top after a pop
  assign ptrBelow = stackPtr - PTR_W'(2);

  ////////////////////////////////////////////////////////////
  // Pointer and depth
  ////////////////////////////////////////////////////////////

  // Pointer wraps freely, so a full stack overwrites its oldest entry
  always_ff @(posedge CLK) begin
    if (RESET) begin
      stackPtr   <= '0;
      stackDepth <= '0;
    end else if (push) begin
      stackPtr <= stackPtr + PTR_W'(1);
      if (stackDepth != (PTR_W+1)'(STACK_DEPTH)) begin
        stackDepth <= stackDepth + (PTR_W+1)'(1);
      end
    end else if (pop) begin
      stackPtr <= stackPtr - PTR_W'(1);
      if (stackDepth != '0) begin
        stackDepth <= stackDepth - (PTR_W+1)'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage and top of stack
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (push) begin
      stack[stackPtr] <= pushData;
      topReg          <= pushData;
    end else if (pop) begin
      topReg <= stack[ptrBelow];
    end
  end

  // Top always mirrors the entry at pointer minus one
  assign returnAddr = topReg;

endmodule

`default_nettype wire

/* source/apbDiagPort.sv */
`timescale 1ns/1ps
`default_nettype none

module apbDiagPort
  import seqPkg::*;
#(
  parameter int ADDR_WIDTH  = 11,
  parameter int STACK_DEPTH = 16
) (
  input  logic                           CLK,
  input  logic                           RESET,
  input  logic                           PSEL,
  input  logic                           PENABLE,
  input  logic                           PWRITE,
  input  logic [11:0]                    PADDR,
  input  logic [31:0]                    PWDATA,
  output logic [31:0]                    PRDATA,
  output logic                           PREADY,
  output logic                           PSLVERR,
  input  logic [ADDR_WIDTH-1:0]          cradr,
  input  logic [$clog2(STACK_DEPTH)-1:0] stackPtr,
  input  logic [$clog2(STACK_DEPTH):0]   stackDepth,
  input  logic [ADDR_WIDTH-1:0]          returnAddr,
  input  logic                           dispParity,
  input  logic [MICROWORD_W-1:0]         csReadData,
  output logic                           run,
  output logic [ADDR_WIDTH-1:0]          diagAddr,
  output logic                           csWrite,
  output logic [ADDR_WIDTH-1:0]          csIndex,
  output logic [MICROWORD_W-1:0]         csWriteData
);

  logic        access;
  logic        csHit;
  logic        mapped;
  logic        readOnly;
  logic [11:0] csOffset;

  // Zero wait states, the access phase is always one cycle
  assign access = PSEL & PENABLE;
  assign PREADY = 1'b1;

  ////////////////////////////////////////////////////////////
  // Control store window
  ////////////////////////////////////////////////////////////

  assign csHit       = (PADDR >= CS_BASE);
  assign csOffset    = PADDR - CS_BASE;
  assign csIndex     = ADDR_WIDTH'(csOffset[11:2]);
  assign csWriteData = PWDATA[MICROWORD_W-1:0];

  // Store is locked while the sequencer fetches from it
  assign csWrite = access & PWRITE & csHit & ~run;

  ////////////////////////////////////////////////////////////
  // Register decode and read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    PRDATA   = '0;
    mapped   = 1'b1;
    readOnly = 1'b0;
    if (csHit) begin
      PRDATA = run ? '0 : 32'(csReadData);
    end else begin
      case (PADDR)
        REG_CTRL:   PRDATA = {31'b0, run};
        REG_DIAG:   PRDATA = 32'(diagAddr);
        REG_CRADR: begin
          PRDATA   = 32'(cradr);
          readOnly = 1'b1;
        end
        REG_STACK: begin
          // Parity at 16, depth at 8..4, pointer at 3..0
          PRDATA   = 32'({dispParity, 7'b0, 5'(stackDepth), 4'(stackPtr)});
          readOnly = 1'b1;
        end
        REG_RETURN: begin
          PRDATA   = 32'(returnAddr);
          readOnly = 1'b1;
        end
        default:    mapped = 1'b0;
      endcase
    end
  end

  assign PSLVERR = access & (~mapped | (readOnly & PWRITE) | (csHit & run));

  ////////////////////////////////////////////////////////////
  // Run and diagnostic address registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      run      <= 1'b0;
      diagAddr <= '0;
    end else if (access && PWRITE && !csHit) begin
      case (PADDR)
        REG_CTRL: run      <= PWDATA[0];
        REG_DIAG: diagAddr <= PWDATA[ADDR_WIDTH-1:0];
        default:  ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/controlStore.sv */
`timescale 1ns/1ps
`default_nettype none

module controlStore
  import seqPkg::*;
#(
  parameter int ADDR_WIDTH = 11
) (
  input  logic                   CLK,
  input  logic [ADDR_WIDTH-1:0]  cradr,
  output logic [MICROWORD_W-1:0] microword,
  input  logic                   csWrite,
  input  logic [ADDR_WIDTH-1:0]  csIndex,
  input  logic [MICROWORD_W-1:0] csWriteData,
  output logic [MICROWORD_W-1:0] csReadData
);

  localparam int WORDS = 2 ** ADDR_WIDTH;

  logic [MICROWORD_W-1:0] cram [WORDS];

  ////////////////////////////////////////////////////////////
  // Load port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (csWrite) begin
      cram[csIndex] <= csWriteData;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////

  // Sequencer side, the microword follows cradr within the cycle
  assign microword = cram[cradr];

  // Readback for loading checks
  assign csReadData = cram[csIndex];

endmodule

`default_nettype wire

/* source/microSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module microSequencer
  import seqPkg::*;
#(
  parameter int ADDR_WIDTH  = 11,
  parameter int STACK_DEPTH = 16
) (
  input  logic                   CLK,
  input  logic                   RESET,
  input  logic                   PSEL,
  input  logic                   PENABLE,
  input  logic                   PWRITE,
  input  logic [11:0]            PADDR,
  input  logic [31:0]            PWDATA,
  output logic [31:0]            PRDATA,
  output logic                   PREADY,
  output logic                   PSLVERR,
  input  logic                   trap,
  input  logic [7:0]             conditions,
  input  logic [3:0]             dispNibble,
  input  logic [ADDR_WIDTH-1:0]  irJump,
  output logic [ADDR_WIDTH-1:0]  cradr,
  output logic [MICROWORD_W-1:0] microword
);

  localparam int PTR_W = $clog2(STACK_DEPTH);

  dispOp_t                  muxSel;
  logic                     advance;
  logic                     forceOnes;
  logic                     push;
  logic                     pop;
  logic                     dispParity;
  logic                     run;
  logic [ADDR_WIDTH-1:0]    diagAddr;
  logic [ADDR_WIDTH-1:0]    returnAddr;
  logic [PTR_W-1:0]         stackPtr;
  logic [PTR_W:0]           stackDepth;
  logic                     csWrite;
  logic [ADDR_WIDTH-1:0]    csIndex;
  logic [MICROWORD_W-1:0]   csWriteData;
  logic [MICROWORD_W-1:0]   csReadData;

  // Microword fields
  logic [JUMP_W-1:0] jumpField;
  logic [OP_W-1:0]   opField;
  logic [COND_W-1:0] condField;

  assign jumpField = microword[JUMP_W-1:0];
  assign opField   = microword[JUMP_W+OP_W-1:JUMP_W];
  assign condField = microword[MICROWORD_W-1:JUMP_W+OP_W];

  seqControl seqControl_inst (
    .op         (dispOp_t'(opField)),
    .cond       (condField),
    .run        (run),
    .trap       (trap),
    .muxSel     (muxSel),
    .advance    (advance),
    .forceOnes  (forceOnes),
    .push       (push),
    .pop        (pop),
    .dispParity (dispParity)
  );

  nextAddress #(.ADDR_WIDTH(ADDR_WIDTH)) nextAddress_inst (
    .CLK        (CLK),
    .RESET      (RESET),
    .advance    (advance),
    .forceOnes  (forceOnes),
    .muxSel     (muxSel),
    .jump       (jumpField),
    .cond       (condField),
    .conditions (conditions),
    .dispNibble (dispNibble),
    .irJump     (irJump),
    .diagAddr   (diagAddr),
    .returnAddr (returnAddr),
    .cradr      (cradr)
  );

  // The current address is pushed on the same edge that loads the next one
  returnStack #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .STACK_DEPTH (STACK_DEPTH)
  ) returnStack_inst (
    .CLK        (CLK),
    .RESET      (RESET),
    .push       (push),
    .pop        (pop),
    .pushData   (cradr),
    .returnAddr (returnAddr),
    .stackPtr   (stackPtr),
    .stackDepth (stackDepth)
  );

  controlStore #(.ADDR_WIDTH(ADDR_WIDTH)) controlStore_inst (
    .CLK         (CLK),
    .cradr       (cradr),
    .microword   (microword),
    .csWrite     (csWrite),
    .csIndex     (csIndex),
    .csWriteData (csWriteData),
    .csReadData  (csReadData)
  );

  apbDiagPort #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .STACK_DEPTH (STACK_DEPTH)
  ) apbDiagPort_inst (
    .CLK         (CLK),
    .RESET       (RESET),
    .PSEL        (PSEL),
    .PENABLE     (PENABLE),
    .PWRITE      (PWRITE),
    .PADDR       (PADDR),
    .PWDATA      (PWDATA),
    .PRDATA      (PRDATA),
    .PREADY      (PREADY),
    .PSLVERR     (PSLVERR),
    .cradr       (cradr),
    .stackPtr    (stackPtr),
    .stackDepth  (stackDepth),
    .returnAddr  (returnAddr),
    .dispParity  (dispParity),
    .csReadData  (csReadData),
    .run         (run),
    .diagAddr    (diagAddr),
    .csWrite     (csWrite),
    .csIndex     (csIndex),
    .csWriteData (csWriteData)
  );

endmodule

`default_nettype wire

/* source/seqControl.sv */
`timescale 1ns/1ps
`default_nettype none

module seqControl
  import seqPkg::*;
(
  input  dispOp_t           op,
  input  logic [COND_W-1:0] cond,
  input  logic              run,
  input  logic              trap,
  output dispOp_t           muxSel,
  output logic              advance,
  output logic              forceOnes,
  output logic              push,
  output logic              pop,
  output logic              dispParity
);

  logic isCall;
  logic isReturn;

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////

  assign isCall   = (op == DISP_CALL);
  assign isReturn = (op == DISP_RETURN);

  // Trap overrides the dispatch, so the mux is parked on J alone
  always_comb begin
    if (trap) begin
      muxSel = DISP_NONE;
    end else begin
      muxSel = op;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequencing controls
  ////////////////////////////////////////////////////////////

  // A trap steps the sequencer even when halted
  assign advance   = run | trap;
  assign forceOnes = trap;

  // Trap counts as a call and saves the interrupted address
  assign push = (isCall | trap) & advance;

  // No pop under trap, the return would be lost otherwise
  assign pop = isReturn & ~trap & run;

  // Diagnostic parity over the dispatch fields
  assign dispParity = ^{op, cond};

endmodule

`default_nettype wire

/* verification/microSequencerTb.sv */
`timescale 1ns/1ps
`default_nettype none

module microSequencerTb
  import seqPkg::*;
();

  // Nine address bits keep the whole store inside the APB window
  localparam int AW      = 9;
  localparam int TIMEOUT = 20;

  logic          CLK;
  logic          RESET;
  logic          PSEL;
  logic          PENABLE;
  logic          PWRITE;
  logic [11:0]   PADDR;
  logic [31:0]   PWDATA;
  logic [31:0]   PRDATA;
  logic          PREADY;
  logic          PSLVERR;
  logic          trap;
  logic [7:0]    conditions;
  logic [3:0]    dispNibble;
  logic [AW-1:0] irJump;
  logic [AW-1:0] cradr;
  logic [16:0]   microword;

  // Model state
  logic [16:0]   tbMem [2**AW];
  logic [AW-1:0] mStack [16];
  logic [3:0]    mPtr;
  logic [4:0]    mDepth;
  logic [AW-1:0] modelAdr;
  logic [AW-1:0] diagModel;
  logic          runModel;
  logic          tracking;
  int            errorCount;
  int            checkCount;
  int            testCount;
  int            failCount;

  microSequencer #(.ADDR_WIDTH(AW), .STACK_DEPTH(16)) microSequencer_inst (
    .CLK(CLK), .RESET(RESET), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
    .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY),
    .PSLVERR(PSLVERR), .trap(trap), .conditions(conditions),
    .dispNibble(dispNibble), .irJump(irJump), .cradr(cradr), .microword(microword)
  );

  always #20 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [AW-1:0] refNext(
    input logic [AW-1:0] cur, input logic [16:0] word, input logic trapIn,
    input logic runIn, input logic [7:0] cond8, input logic [3:0] nib,
    input logic [AW-1:0] ir, input logic [AW-1:0] diag,
    inout logic [AW-1:0] stk [16], inout logic [3:0] ptr, inout logic [4:0] depth);
    logic [AW-1:0] j;
    logic [2:0]    op;
    logic [2:0]    c;
    logic [AW-1:0] nxt;
    j   = word[AW-1:0];
    op  = word[13:11];
    c   = word[16:14];
    nxt = cur;
    if (trapIn || (runIn && op == DISP_CALL)) begin
      // Call or trap saves the current address
      stk[ptr] = cur;
      ptr = ptr + 4'd1;
      if (depth != 5'd16) depth = depth + 5'd1;
      nxt = trapIn ? '1 : j;
    end else if (runIn) begin
      case (op)
        DISP_SKIP:   nxt = j | {{(AW-1){1'b0}}, cond8[c]};
        DISP_NIBBLE: nxt = j | {{(AW-4){1'b0}}, nib};
        DISP_IR:     nxt = j | ir;
        DISP_DIAG:   nxt = j | diag;
        DISP_RETURN: begin
          nxt = j | stk[ptr-4'd1];
          ptr = ptr - 4'd1;
          if (depth != 5'd0) depth = depth - 5'd1;
        end
        default:     nxt = j;
      endcase
    end
    return nxt;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
      errorCount++;
    end
  endtask

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    errorCount++;
  endtask

  // The model steps on every edge and cradr must follow it
  always @(posedge CLK) begin
    if (tracking) begin
      modelAdr = refNext(modelAdr, tbMem[modelAdr], trap, runModel, conditions,
                         dispNibble, irJump, diagModel, mStack, mPtr, mDepth);
      #1;
      checkValue("cradr", 32'(cradr), 32'(modelAdr));
      // Every word is loaded before the first run
      if (runModel) begin
        checkValue("microword", 32'(microword), 32'(tbMem[modelAdr]));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // APB master
  ////////////////////////////////////////////////////////////

  task automatic apbAccess(input logic [11:0] addr, input logic wr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
    int tries;
    @(negedge CLK);
    PSEL = 1'b1;
    PENABLE = 1'b0;
    PWRITE = wr;
    PADDR = addr;
    PWDATA = wdata;
    @(negedge CLK);
    PENABLE = 1'b1;
    #5;
    tries = 0;
    while (PREADY !== 1'b1 && tries < TIMEOUT) begin
      @(negedge CLK);
      #5;
      tries++;
    end
    if (PREADY !== 1'b1) begin
      $display("APB access to 0x%0h timed out waiting for PREADY", addr);
      $display("FAIL: see errors above");
      $finish;
    end
    rdata = PRDATA;
    err = PSLVERR;
    @(posedge CLK);
    @(negedge CLK);
    PSEL = 1'b0;
    PENABLE = 1'b0;
    // Model registers follow the committed write
    if (wr && !err) begin
      if (addr == REG_CTRL) runModel = wdata[0];
      if (addr == REG_DIAG) diagModel = wdata[AW-1:0];
      if (addr >= CS_BASE) tbMem[addr[AW+1:2] - 9'(CS_BASE >> 2)] = wdata[16:0];
    end
  endtask

  task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data,
                          output logic err);
    logic [31:0] unused;
    apbAccess(addr, 1'b1, data, unused, err);
  endtask

  task automatic apbRead(input logic [11:0] addr, output logic [31:0] data,
                         output logic err);
    apbAccess(addr, 1'b0, 32'd0, data, err);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [11:0] csAddr(input logic [AW-1:0] idx);
    return 12'(CS_BASE) + {1'b0, idx, 2'b00};
  endfunction

  task automatic setRun(input logic value);
    logic err;
    apbWrite(REG_CTRL, {31'd0, value}, err);
    if (err) reportFailure("unexpected PSLVERR on write to the control register");
  endtask

  task automatic loadWord(input logic [AW-1:0] idx, input logic [16:0] word);
    logic err;
    apbWrite(csAddr(idx), {15'd0, word}, err);
    if (err) reportFailure("unexpected PSLVERR on a control store write");
  endtask

  task automatic runCycles(input int n);
    logic [31:0] r;
    repeat (n) begin
      @(negedge CLK);
      r = $urandom;
      conditions = r[7:0];
      dispNibble = r[11:8];
      irJump = r[20:12];
    end
  endtask

  // Place a word at the current address and let it execute
  task automatic patchStep(input dispOp_t op, input logic [AW-1:0] j);
    logic [31:0] r;
    r = $urandom;
    loadWord(modelAdr, {r[2:0], op, 2'b00, j});
    setRun(1'b1);
    setRun(1'b0);
  endtask

  task automatic checkStack();
    logic [31:0] data;
    logic err;
    apbRead(REG_STACK, data, err);
    checkValue("REG_STACK", {15'd0, data[16:0]},
               {15'd0, ^tbMem[modelAdr][16:11], 7'd0, mDepth, mPtr});
    apbRead(REG_RETURN, data, err);
    checkValue("REG_RETURN", data, 32'(mStack[mPtr-4'd1]));
  endtask

  task automatic finishTest(input string name, input int errBefore);
    testCount++;
    if (errorCount == errBefore) begin
      $display("test %s: passed", name);
    end else begin
      failCount++;
      $display("test %s: failed", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] data;
    logic        err;
    logic [AW-1:0] hold;
    int          e;
    void'($urandom(32041));
    CLK = 0;
    RESET = 1;
    PSEL = 0;
    PENABLE = 0;
    PWRITE = 0;
    PADDR = '0;
    PWDATA = '0;
    trap = 0;
    conditions = '0;
    dispNibble = '0;
    irJump = '0;
    tracking = 0;
    errorCount = 0;
    checkCount = 0;
    testCount = 0;
    failCount = 0;
    modelAdr = '0;
    mPtr = '0;
    mDepth = '0;
    diagModel = '0;
    runModel = 0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RESET = 0;
    tracking = 1;

    e = errorCount;
    apbRead(REG_CTRL, data, err);
    checkValue("REG_CTRL", data, 32'd0);
    checkValue("PSLVERR", 32'(err), 32'd0);
    apbRead(REG_CRADR, data, err);
    checkValue("REG_CRADR", data, 32'd0);
    apbRead(REG_STACK, data, err);
    checkValue("REG_STACK", {23'd0, data[8:0]}, 32'd0);
    finishTest("reset", e);

    // Fill the store with NONE, SKIP and NIBBLE words
    e = errorCount;
    for (int i = 0; i < 2**AW; i++) begin
      r = $urandom;
      loadWord(AW'(i), {r[13:11], 3'(r[31:16] % 3), 2'b00, r[AW-1:0]});
    end
    repeat (64) begin
      r = $urandom;
      apbRead(csAddr(r[AW-1:0]), data, err);
      checkValue("csReadData", data, {15'd0, tbMem[r[AW-1:0]]});
    end
    setRun(1'b1);
    apbWrite(csAddr(9'd3), 32'd0, err);
    if (!err) reportFailure("control store write while running gave no PSLVERR");
    apbWrite(REG_CRADR, 32'd0, err);
    if (!err) reportFailure("write to the read-only cradr register gave no PSLVERR");
    setRun(1'b0);
    finishTest("control store", e);

    e = errorCount;
    setRun(1'b1);
    runCycles(200);
    setRun(1'b0);
    hold = modelAdr;
    runCycles(5);
    checkValue("cradr hold", 32'(cradr), 32'(hold));
    finishTest("random program", e);

    e = errorCount;
    repeat (4) begin
      r = $urandom;
      apbWrite(REG_DIAG, {23'd0, r[AW-1:0]}, err);
      patchStep(DISP_DIAG, r[AW+15:16]);
      r = $urandom;
      patchStep(DISP_IR, r[AW-1:0]);
    end
    finishTest("ir and diag dispatch", e);

    e = errorCount;
    repeat (20) begin
      r = $urandom;
      patchStep(DISP_CALL, r[AW-1:0]);
    end
    checkStack();
    repeat (22) begin
      r = $urandom;
      patchStep(DISP_RETURN, r[AW-1:0]);
      checkStack();
    end
    finishTest("call and return", e);

    e = errorCount;
    loadWord('1, {3'd0, DISP_NONE, 2'b00, 9'h1FF});
    setRun(1'b1);
    @(negedge CLK);
    hold = modelAdr;
    trap = 1;
    @(negedge CLK);
    trap = 0;
    setRun(1'b0);
    checkValue("cradr after trap", 32'(cradr), 32'h1FF);
    apbRead(REG_RETURN, data, err);
    checkValue("REG_RETURN", data, 32'(hold));
    r = $urandom;
    patchStep(DISP_RETURN, r[AW-1:0]);
    // Halted trap, then return from the trap entry
    hold = modelAdr;
    @(negedge CLK);
    trap = 1;
    @(negedge CLK);
    trap = 0;
    checkValue("cradr after halted trap", 32'(cradr), 32'h1FF);
    checkStack();
    apbRead(REG_RETURN, data, err);
    checkValue("REG_RETURN", data, 32'(hold));
    r = $urandom;
    patchStep(DISP_RETURN, r[AW-1:0]);
    finishTest("trap", e);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testCount, failCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
common/seqPkg.sv
source/seqControl.sv
crAddress/nextAddress.sv
crAddress/returnStack.sv
source/controlStore.sv
source/apbDiagPort.sv
source/microSequencer.sv
verification/microSequencerTb.sv
